//--- files.f
+incdir+hdl
hdl/div_pkg.sv
hdl/div_special_case.sv
hdl/div_operand_prep.sv
hdl/div_restoring_core.sv
hdl/div_result_sel.sv
hdl/div_unit_top.sv
verification/div_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module div_unit_tb \
  -f files.f -o div_unit_sim

out=$(./obj_dir/div_unit_sim)
echo "$out"

# the result line decides the exit status
echo "$out" | grep -q "^TEST PASS$"

//--- verification/div_unit_tb.sv
/*
 * testbench for the integer divide unit: directed and random operations,
 * reference model, result checker, latency and back-pressure checks
 */

`timescale 1ns/1ps
`include "div_consts.svh"

module div_unit_tb import div_pkg::*; ();

  localparam int NUM_RANDOM     = 350;
  localparam int TIMEOUT_CYCLES = (NUM_RANDOM + 60) * 75;  // about 75 cycles per op at most

  logic                 clk;
  logic                 rst_n;
  logic                 div_valid_i;
  div_op_e              div_op_i;
  logic [`DIV_XLEN-1:0] dividend_i;
  logic [`DIV_XLEN-1:0] divisor_i;
  logic                 result_ready_i;
  logic [`DIV_XLEN-1:0] div_out_o;
  logic                 div_stall_o;
  logic                 result_ok_o;

  logic [`DIV_XLEN-1:0] exp_q [$];  // expected results in start order
  int                   errors = 0;
  int                   checks = 0;
  int                   cycle_cnt = 0;
  div_op_e              op_list [8] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU,
                                        OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};

  div_unit_top u_div_unit_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .div_out_o      (div_out_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

  always #20 clk = ~clk;

  // ==========================================================================
  // reference model
  // ==========================================================================
  function automatic logic is_known(div_op_e op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  endfunction

  function automatic logic is_word(div_op_e op);
    return op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  endfunction

  function automatic logic is_special(div_op_e op, logic [63:0] a, logic [63:0] b);
    logic zero;
    logic ovf;
    zero = is_word(op) ? (b[31:0] == 32'h0) : (b == 64'h0);
    if (is_word(op)) begin
      ovf = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
    end else begin
      ovf = (a == 64'h8000_0000_0000_0000) && (b == 64'hffff_ffff_ffff_ffff);
    end
    return zero || (ovf && (op inside {OP_DIV, OP_REM, OP_DIVW, OP_REMW}));
  endfunction

  function automatic int latency_of(div_op_e op, logic [63:0] a, logic [63:0] b);
    if (is_special(op, a, b)) return 1;
    return is_word(op) ? `DIV_ITER_W + 1 : `DIV_ITER_D + 1;
  endfunction

  function automatic logic [63:0] ref_div(div_op_e op, logic [63:0] a, logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic        [31:0] w;
    logic        [63:0] res;
    sa  = a;
    sb  = b;
    wa  = a[31:0];
    wb  = b[31:0];
    w   = 32'h0;
    res = 64'h0;
    case (op)
      OP_DIV: begin
        if (b == 64'h0) res = '1;
        else if (is_special(op, a, b)) res = a;   // overflow
        else res = sa / sb;
      end
      OP_REM: begin
        if (b == 64'h0) res = a;
        else if (!is_special(op, a, b)) res = sa % sb;
      end
      OP_DIVU: res = (b == 64'h0) ? '1 : a / b;
      OP_REMU: res = (b == 64'h0) ? a : a % b;
      OP_DIVW: begin
        if (b[31:0] == 32'h0) w = '1;
        else if (is_special(op, a, b)) w = a[31:0];
        else w = wa / wb;
      end
      OP_REMW: begin
        if (b[31:0] == 32'h0) w = a[31:0];
        else if (!is_special(op, a, b)) w = wa % wb;
      end
      OP_DIVUW: w = (b[31:0] == 32'h0) ? '1 : a[31:0] / b[31:0];
      OP_REMUW: w = (b[31:0] == 32'h0) ? a[31:0] : a[31:0] % b[31:0];
      default: ;
    endcase
    if (is_word(op)) res = {{32{w[31]}}, w};   // word results sign-extend
    return res;
  endfunction

  // ==========================================================================
  // error reporting
  // ==========================================================================
  task automatic mismatch_error(string name, logic [63:0] got, logic [63:0] exp);
    errors++;
    $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
  endtask

  task automatic flag_failure(string what);
    errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================
  task automatic run_op(div_op_e op, logic [63:0] a, logic [63:0] b, int hold);
    int          lat;
    int          exp_lat;
    logic [63:0] held;
    exp_lat = latency_of(op, a, b);
    @(posedge clk);
    div_valid_i <= 1'b1;
    div_op_i    <= op;
    dividend_i  <= a;
    divisor_i   <= b;
    @(negedge clk);
    assert (div_stall_o == (exp_lat != 1)) else
      mismatch_error("div_stall_o", 64'(div_stall_o), 64'(exp_lat != 1));
    @(posedge clk);                       // accepting edge
    exp_q.push_back(ref_div(op, a, b));
    div_valid_i <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      if (!result_ok_o) begin
        assert (div_stall_o) else flag_failure("div_stall_o low while iterating");
      end
    end while (!result_ok_o && lat < 70);
    assert (lat == exp_lat) else mismatch_error("result_ok_o latency", 64'(lat), 64'(exp_lat));
    assert (!div_stall_o) else flag_failure("div_stall_o high with a result waiting");
    held = div_out_o;
    repeat (hold) begin
      @(posedge clk);
      div_valid_i <= 1'b1;                // start pulse, ignored in ST_DONE
      div_op_i    <= OP_DIVU;
      dividend_i  <= ~a;
      divisor_i   <= 64'd3;
      @(negedge clk);
      assert (result_ok_o) else flag_failure("result_ok_o dropped before the result was taken");
      assert (div_out_o == held) else mismatch_error("div_out_o", div_out_o, held);
    end
    @(posedge clk);
    div_valid_i    <= 1'b0;
    result_ready_i <= 1'b1;
    @(posedge clk);                       // result consumed
    result_ready_i <= 1'b0;
    @(negedge clk);
    assert (!result_ok_o && !div_stall_o) else
      flag_failure("divider not idle after the result was consumed");
  endtask

  task automatic run_invalid(logic [7:0] code, logic [63:0] a, logic [63:0] b);
    @(posedge clk);
    div_valid_i <= 1'b1;
    div_op_i    <= div_op_e'(code);
    dividend_i  <= a;
    divisor_i   <= b;
    @(negedge clk);
    assert (!div_stall_o) else flag_failure("div_stall_o raised for an invalid operation code");
    @(posedge clk);
    div_valid_i <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      assert (!div_stall_o && !result_ok_o) else
        flag_failure("an invalid operation code started the divider");
    end
  endtask

  // compare each consumed result with the value saved at acceptance
  always @(negedge clk) begin
    if (result_ok_o && result_ready_i) begin
      if (exp_q.size() == 0) begin
        flag_failure("result consumed with no operation started");
      end else begin
        checks++;
        assert (div_out_o === exp_q[0]) else mismatch_error("div_out_o", div_out_o, exp_q[0]);
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      errors++;
      $display("Error: run stopped after %0d cycles, the divider did not finish", cycle_cnt);
      $display("errors: %0d, results checked: %0d", errors, checks);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    logic [7:0]  code;
    int          sel;
    void'($urandom(32'hee4d));
    clk            = 1'b0;
    rst_n          = 1'b1;               // reset asserted
    div_valid_i    = 1'b0;
    div_op_i       = div_op_e'(8'h00);
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    assert (!div_stall_o && !result_ok_o) else flag_failure("outputs not idle after reset");

    // all sign combinations
    foreach (op_list[i]) begin
      for (int s = 0; s < 4; s++) begin
        a = s[0] ? -64'd7000001 : 64'd7000001;
        b = s[1] ? -64'd97 : 64'd97;
        run_op(op_list[i], a, b, 0);
      end
    end

    // divide by zero, word forms ignore the upper divisor bits
    foreach (op_list[i]) begin
      run_op(op_list[i], 64'h8765_4321_fedc_ba98, 64'h0, 1);
      run_op(op_list[i], 64'h8765_4321_fedc_ba98, 64'h0000_0013_0000_0000, 2);
    end

    // signed overflow
    run_op(OP_DIV, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 3);
    run_op(OP_REM, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 0);
    run_op(OP_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff, 1);
    run_op(OP_REMW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff, 0);

    run_invalid(8'h00, 64'd100, 64'd7);
    run_invalid(8'h03, 64'd100, 64'd7);
    run_invalid(8'h81, 64'd100, 64'd0);

    // ========================================================================
    // random operations
    // ========================================================================
    repeat (NUM_RANDOM) begin
      sel  = int'($urandom_range(0, 7));
      code = ($urandom_range(0, 5) == 0) ? 8'($urandom) : 8'(1 << $urandom_range(0, 7));
      a    = {$urandom, $urandom} >> $urandom_range(0, 63);
      b    = {$urandom, $urandom} >> $urandom_range(0, 63);
      if ($urandom_range(0, 1) == 1) a = -a;
      if ($urandom_range(0, 1) == 1) b = -b;
      case (sel)
        0: b = 64'h0;
        1: b = {$urandom, 32'h0};            // word zero only
        2: begin
          a = 64'h8000_0000_0000_0000;
          b = 64'hffff_ffff_ffff_ffff;
        end
        3: begin
          a = {$urandom, 32'h8000_0000};
          b = {$urandom, 32'hffff_ffff};
        end
        default: ;
      endcase
      if (is_known(div_op_e'(code))) run_op(div_op_e'(code), a, b, int'($urandom_range(0, 3)));
      else run_invalid(code, a, b);
    end

    repeat (2) @(posedge clk);
    assert (exp_q.size() == 0) else flag_failure("some started operations never returned");
    $display("errors: %0d, results checked: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- hdl/div_unit_top.sv
/*
 * integer divide unit top level
 */

`timescale 1ns/1ps
`include "div_consts.svh"

module div_unit_top import div_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 div_valid_i,
  input  div_op_e              div_op_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  input  logic                 result_ready_i,
  output logic [`DIV_XLEN-1:0] div_out_o,
  output logic                 div_stall_o,
  output logic                 result_ok_o
);

  // start path, combinational from the raw inputs
  logic                  special;
  logic [`DIV_XLEN-1:0]  special_result;
  logic [`DIV_XLEN-1:0]  dvd_mag;
  logic [`DIV_XLEN-1:0]  dvs_mag;
  logic                  quo_neg;
  logic                  rem_neg;
  logic [`DIV_CNT_W-1:0] iter_cnt;

  // latched state toward the result select
  div_op_e               core_op;
  logic                  core_special;
  logic [`DIV_XLEN-1:0]  core_quotient;
  logic [`DIV_XLEN-1:0]  core_remainder;
  logic                  core_quo_neg;
  logic                  core_rem_neg;

  div_special_case u_special (
    .div_op_i         (div_op_i),
    .dividend_i       (dividend_i),
    .divisor_i        (divisor_i),
    .special_o        (special),
    .special_result_o (special_result)
  );

  div_operand_prep u_prep (
    .div_op_i   (div_op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .dvd_mag_o  (dvd_mag),
    .dvs_mag_o  (dvs_mag),
    .quo_neg_o  (quo_neg),
    .rem_neg_o  (rem_neg),
    .iter_cnt_o (iter_cnt)
  );

  div_restoring_core u_core (
    .clk              (clk),
    .rst_n            (rst_n),
    .div_valid_i      (div_valid_i),
    .div_op_i         (div_op_i),
    .special_i        (special),
    .special_result_i (special_result),
    .dvd_mag_i        (dvd_mag),
    .dvs_mag_i        (dvs_mag),
    .quo_neg_i        (quo_neg),
    .rem_neg_i        (rem_neg),
    .iter_cnt_i       (iter_cnt),
    .result_ready_i   (result_ready_i),
    .op_o             (core_op),
    .special_o        (core_special),
    .quotient_o       (core_quotient),
    .remainder_o      (core_remainder),
    .quo_neg_o        (core_quo_neg),
    .rem_neg_o        (core_rem_neg),
    .div_stall_o      (div_stall_o),
    .result_ok_o      (result_ok_o)
  );

  div_result_sel u_sel (
    .op_i        (core_op),
    .special_i   (core_special),
    .quotient_i  (core_quotient),
    .remainder_i (core_remainder),
    .quo_neg_i   (core_quo_neg),
    .rem_neg_i   (core_rem_neg),
    .div_out_o   (div_out_o)
  );

endmodule

//--- hdl/div_result_sel.sv
/*
 * result select: sign restore, quotient or remainder pick,
 * word-form sign extension
 */

`timescale 1ns/1ps
`include "div_consts.svh"

module div_result_sel import div_pkg::*; (
  input  div_op_e               op_i,
  input  logic                  special_i,
  input  logic [`DIV_XLEN-1:0]  quotient_i,
  input  logic [`DIV_XLEN-1:0]  remainder_i,
  input  logic                  quo_neg_i,
  input  logic                  rem_neg_i,
  output logic [`DIV_XLEN-1:0]  div_out_o
);

  logic                 rem_op;
  logic                 word_op;
  logic [`DIV_XLEN-1:0] raw_val;
  logic                 neg;
  logic [`DIV_XLEN-1:0] signed_val;

  assign rem_op  = op_i inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  assign word_op = op_i inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};

  // pick the half of the core register this op wants
  assign raw_val = rem_op ? remainder_i : quotient_i;
  assign neg     = rem_op ? rem_neg_i : quo_neg_i;

  assign signed_val = neg ? (~raw_val + 1'b1) : raw_val;

  always_comb begin
    if (special_i) begin
      div_out_o = quotient_i;   // fixed result already in final form
    end else if (word_op) begin
      div_out_o = {{(`DIV_XLEN-`DIV_HALF){signed_val[`DIV_HALF-1]}},
                   signed_val[`DIV_HALF-1:0]};
    end else begin
      div_out_o = signed_val;
    end
  end

endmodule

//--- hdl/div_restoring_core.sv
/*
 * divider controller FSM and restoring shift-subtract datapath,
 * one quotient bit per ST_ITER cycle
 */

`timescale 1ns/1ps
`include "div_consts.svh"

module div_restoring_core import div_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  div_valid_i,
  input  div_op_e               div_op_i,
  input  logic                  special_i,
  input  logic [`DIV_XLEN-1:0]  special_result_i,
  input  logic [`DIV_XLEN-1:0]  dvd_mag_i,
  input  logic [`DIV_XLEN-1:0]  dvs_mag_i,
  input  logic                  quo_neg_i,
  input  logic                  rem_neg_i,
  input  logic [`DIV_CNT_W-1:0] iter_cnt_i,
  input  logic                  result_ready_i,
  output div_op_e               op_o,
  output logic                  special_o,
  output logic [`DIV_XLEN-1:0]  quotient_o,
  output logic [`DIV_XLEN-1:0]  remainder_o,
  output logic                  quo_neg_o,
  output logic                  rem_neg_o,
  output logic                  div_stall_o,
  output logic                  result_ok_o
);

  div_state_e             state_q, state_nxt;
  div_op_e                op_q;
  logic                   special_q;
  logic                   quo_neg_q;
  logic                   rem_neg_q;
  logic [2*`DIV_XLEN-1:0] rq_q;         // remainder : quotient
  logic [`DIV_XLEN-1:0]   dvs_q;
  logic [`DIV_CNT_W-1:0]  cnt_q;
  logic [`DIV_CNT_W-1:0]  cnt_dec;
  logic                   op_known;
  logic                   start;
  logic [`DIV_XLEN:0]     part_rem;     // shifted remainder, one bit wider
  logic [`DIV_XLEN+1:0]   trial;
  logic [2*`DIV_XLEN-1:0] rq_step;

  assign op_known = div_op_i inside {OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW,
                                     OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  assign start    = (state_q == ST_IDLE) && div_valid_i && op_known;
  assign cnt_dec  = cnt_q - 1'b1;

  // ==========================================================================
  // one restoring step
  // ==========================================================================
  assign part_rem = rq_q[2*`DIV_XLEN-1:`DIV_XLEN-1];
  assign trial    = {1'b0, part_rem} - {2'b00, dvs_q};

  always_comb begin
    if (trial[`DIV_XLEN+1]) begin   // negative, restore
      rq_step = {part_rem[`DIV_XLEN-1:0], rq_q[`DIV_XLEN-2:0], 1'b0};
    end else begin
      rq_step = {trial[`DIV_XLEN-1:0], rq_q[`DIV_XLEN-2:0], 1'b1};
    end
  end

  // ==========================================================================
  // controller
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst_n) state_q <= ST_IDLE;
    else       state_q <= state_nxt;
  end

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      ST_IDLE: if (start) state_nxt = special_i ? ST_DONE : ST_ITER;
      ST_ITER: if (cnt_dec == '0) state_nxt = ST_DONE;   // last bit this cycle
      ST_DONE: if (result_ready_i) state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      op_q      <= div_op_e'(8'h00);
      special_q <= 1'b0;
      quo_neg_q <= 1'b0;
      rem_neg_q <= 1'b0;
      rq_q      <= '0;
      dvs_q     <= '0;
      cnt_q     <= '0;
    end else begin
      case (state_q)
        ST_IDLE: if (start) begin
          op_q      <= div_op_i;
          special_q <= special_i;
          quo_neg_q <= quo_neg_i & ~special_i;
          rem_neg_q <= rem_neg_i & ~special_i;
          rq_q      <= {{`DIV_XLEN{1'b0}}, special_i ? special_result_i : dvd_mag_i};
          dvs_q     <= dvs_mag_i;
          cnt_q     <= iter_cnt_i;
        end
        ST_ITER: begin
          rq_q  <= rq_step;
          cnt_q <= cnt_dec;
        end
        default: ;  // ST_DONE holds its result
      endcase
    end
  end

  // outputs to the result select
  assign op_o        = op_q;
  assign special_o   = special_q;
  assign quotient_o  = rq_q[`DIV_XLEN-1:0];
  assign remainder_o = rq_q[2*`DIV_XLEN-1:`DIV_XLEN];
  assign quo_neg_o   = quo_neg_q;
  assign rem_neg_o   = rem_neg_q;

  assign div_stall_o = (start && !special_i) || (state_q == ST_ITER);
  assign result_ok_o = (state_q == ST_DONE);

endmodule

//--- hdl/div_operand_prep.sv
/*
 * start-cycle operand preparation: magnitudes, result signs
 * and iteration count for the restoring core
 */

`timescale 1ns/1ps
`include "div_consts.svh"

module div_operand_prep import div_pkg::*; (
  input  div_op_e               div_op_i,
  input  logic [`DIV_XLEN-1:0]  dividend_i,
  input  logic [`DIV_XLEN-1:0]  divisor_i,
  output logic [`DIV_XLEN-1:0]  dvd_mag_o,
  output logic [`DIV_XLEN-1:0]  dvs_mag_o,
  output logic                  quo_neg_o,
  output logic                  rem_neg_o,
  output logic [`DIV_CNT_W-1:0] iter_cnt_o
);

  localparam logic [`DIV_CNT_W-1:0] ITER_D = `DIV_ITER_D;
  localparam logic [`DIV_CNT_W-1:0] ITER_W = `DIV_ITER_W;

  logic                 word_op;
  logic                 signed_op;
  logic [`DIV_XLEN-1:0] dvd_ext;
  logic [`DIV_XLEN-1:0] dvs_ext;
  logic                 dvd_neg;
  logic                 dvs_neg;
  logic [`DIV_XLEN-1:0] dvd_abs;

  assign word_op   = div_op_i inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  assign signed_op = div_op_i inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};

  // widen the low word first, sign or zero by operation
  always_comb begin
    dvd_ext = dividend_i;
    dvs_ext = divisor_i;
    if (word_op) begin
      dvd_ext = {{(`DIV_XLEN-`DIV_HALF){signed_op & dividend_i[`DIV_HALF-1]}},
                 dividend_i[`DIV_HALF-1:0]};
      dvs_ext = {{(`DIV_XLEN-`DIV_HALF){signed_op & divisor_i[`DIV_HALF-1]}},
                 divisor_i[`DIV_HALF-1:0]};
    end
  end

  assign dvd_neg = signed_op & dvd_ext[`DIV_XLEN-1];
  assign dvs_neg = signed_op & dvs_ext[`DIV_XLEN-1];

  // two's complement magnitudes
  assign dvd_abs   = dvd_neg ? (~dvd_ext + 1'b1) : dvd_ext;
  assign dvs_mag_o = dvs_neg ? (~dvs_ext + 1'b1) : dvs_ext;

  // word dividend goes to the top of the low half, 32 shifts are enough
  assign dvd_mag_o = word_op ? {dvd_abs[`DIV_HALF-1:0], {`DIV_HALF{1'b0}}} : dvd_abs;

  assign quo_neg_o  = dvd_neg ^ dvs_neg;
  assign rem_neg_o  = dvd_neg;              // remainder follows the dividend
  assign iter_cnt_o = word_op ? ITER_W : ITER_D;

endmodule

//--- hdl/div_special_case.sv
/*
 * divide by zero and signed overflow detection
 * with the architectural results for both cases
 */

`timescale 1ns/1ps
`include "div_consts.svh"

module div_special_case import div_pkg::*; (
  input  div_op_e               div_op_i,
  input  logic [`DIV_XLEN-1:0]  dividend_i,
  input  logic [`DIV_XLEN-1:0]  divisor_i,
  output logic                  special_o,
  output logic [`DIV_XLEN-1:0]  special_result_o
);

  logic                 known_op;
  logic                 word_op;
  logic                 signed_op;
  logic                 rem_op;
  logic                 div_zero;
  logic                 div_ovf;
  logic                 ovf_dword;
  logic                 ovf_word;
  logic [`DIV_XLEN-1:0] dvd_src;

  // operation class decode
  assign known_op  = div_op_i inside {OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW,
                                      OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  assign word_op   = div_op_i inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  assign signed_op = div_op_i inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
  assign rem_op    = div_op_i inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};

  // word forms only look at the low half of the divisor
  assign div_zero = known_op &&
                    (word_op ? (divisor_i[`DIV_HALF-1:0] == '0) : (divisor_i == '0));

  // most negative value over minus one
  assign ovf_dword = (dividend_i == {1'b1, {(`DIV_XLEN-1){1'b0}}}) && (&divisor_i);
  assign ovf_word  = (dividend_i[`DIV_HALF-1:0] == {1'b1, {(`DIV_HALF-1){1'b0}}}) &&
                     (&divisor_i[`DIV_HALF-1:0]);
  assign div_ovf   = known_op && signed_op && !div_zero &&
                     (word_op ? ovf_word : ovf_dword);

  // dividend as the result would carry it
  assign dvd_src = word_op ?
                   {{(`DIV_XLEN-`DIV_HALF){dividend_i[`DIV_HALF-1]}},
                    dividend_i[`DIV_HALF-1:0]} :
                   dividend_i;

  always_comb begin
    if (div_zero) begin
      special_result_o = rem_op ? dvd_src : '1;   // quotient is all ones
    end else if (div_ovf) begin
      special_result_o = rem_op ? '0 : dvd_src;
    end else begin
      special_result_o = '0;
    end
  end

  assign special_o = div_zero | div_ovf;

endmodule

//--- hdl/div_pkg.sv
/*
 * operation and controller state types for the divide unit
 */

package div_pkg;

  // ==========================================================================
  // one-hot operation codes
  // ==========================================================================
  typedef enum logic [7:0] {
    OP_DIVW  = 8'b0000_0001,  // signed, word
    OP_DIVUW = 8'b0000_0010,  // unsigned, word
    OP_DIVU  = 8'b0000_0100,  // unsigned, 64 bit
    OP_DIV   = 8'b0000_1000,  // signed, 64 bit
    OP_REMW  = 8'b0001_0000,
    OP_REMUW = 8'b0010_0000,
    OP_REMU  = 8'b0100_0000,
    OP_REM   = 8'b1000_0000
  } div_op_e;

  // ==========================================================================
  // divider controller states
  // ==========================================================================
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,  // waiting for a start
    ST_ITER = 2'b01,  // shift-subtract in progress
    ST_DONE = 2'b10   // result held until consumed
  } div_state_e;

endpackage

//--- hdl/div_consts.svh
/*
 * width and iteration count defines for the integer divide unit
 */

`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// data path widths
`define DIV_XLEN   64       // full register width
`define DIV_HALF   32       // word-form width

// restoring iterations, one quotient bit each
`define DIV_ITER_D 64       // div, divu, rem, remu
`define DIV_ITER_W 32       // divw, divuw, remw, remuw

// counter must hold DIV_ITER_D itself
`define DIV_CNT_W  7

`endif
